// File: include/apu_macros.svh
`ifndef APU_MACROS_SVH
`define APU_MACROS_SVH

//////////////////////////////////////////////////////////////
// Cluster configuration
//////////////////////////////////////////////////////////////

// Cores sharing the multiply pool
`define APU_NB_CORES 4

// One multiply unit per two cores
`define APU_NB_UNITS (`APU_NB_CORES / 2)

//////////////////////////////////////////////////////////////
// Multiply unit
//////////////////////////////////////////////////////////////

// Pipeline registers from issue to result
`define APU_MULT_STAGES 2

// Operand and result width
`define APU_WIDTH 32

`endif

// File: source/apu_types_pkg.sv
`include "apu_macros.svh"

//////////////////////////////////////////////////////////////
// Arithmetic data types of the multiply cluster
//////////////////////////////////////////////////////////////

package apu_types_pkg;

   // One source operand, one machine word
   typedef logic [`APU_WIDTH-1:0] apu_operand_t;

   // Value returned to the core
   typedef logic [`APU_WIDTH-1:0] apu_result_t;

   // Full double width product
   typedef logic [2*`APU_WIDTH-1:0] apu_product_t;

   // Integer multiply operations
   typedef enum logic [1:0] {
      op_mul_lo  = 2'd0,  // low word of a*b
      op_mulh_ss = 2'd1,  // high word, both signed
      op_mulh_uu = 2'd2,  // high word, both unsigned
      op_mac_lo  = 2'd3   // low word of a*b plus c
   } apu_op_e;

endpackage

// File: source/apu_cluster_pkg.sv
`include "apu_macros.svh"

//////////////////////////////////////////////////////////////
// Structural types of the multiply cluster
//////////////////////////////////////////////////////////////

package apu_cluster_pkg;

   // Number of the requesting core, carried through the units
   typedef logic [$clog2(`APU_NB_CORES)-1:0] core_tag_t;

   // Number of a multiply unit in the pool
   typedef logic [$clog2(`APU_NB_UNITS)-1:0] unit_idx_t;

   // Arbiter scan outcome for the current cycle
   typedef enum logic {
      arb_idle     = 1'b0,
      arb_granting = 1'b1
   } arb_state_e;

endpackage

// File: source/apu_arbiter.sv
`timescale 1ns/1ps
`include "apu_macros.svh"

module apu_arbiter (
   input  logic                        clk_i,
   input  logic                        reset_i,
   // Core requests
   input  logic                        req_i         [`APU_NB_CORES-1:0],
   input  apu_types_pkg::apu_op_e      op_i          [`APU_NB_CORES-1:0],
   input  apu_types_pkg::apu_operand_t opa_i         [`APU_NB_CORES-1:0],
   input  apu_types_pkg::apu_operand_t opb_i         [`APU_NB_CORES-1:0],
   input  apu_types_pkg::apu_operand_t opc_i         [`APU_NB_CORES-1:0],
   output logic                        ack_o         [`APU_NB_CORES-1:0],
   // Unit issue ports
   input  logic                        unit_ready_i  [`APU_NB_UNITS-1:0],
   output logic                        issue_valid_o [`APU_NB_UNITS-1:0],
   output apu_types_pkg::apu_op_e      issue_op_o    [`APU_NB_UNITS-1:0],
   output apu_types_pkg::apu_operand_t issue_opa_o   [`APU_NB_UNITS-1:0],
   output apu_types_pkg::apu_operand_t issue_opb_o   [`APU_NB_UNITS-1:0],
   output apu_types_pkg::apu_operand_t issue_opc_o   [`APU_NB_UNITS-1:0],
   output apu_cluster_pkg::core_tag_t  issue_tag_o   [`APU_NB_UNITS-1:0]
);

   import apu_types_pkg::*;
   import apu_cluster_pkg::*;

   // First core looked at in the scan
   core_tag_t                ptr_q;

   core_tag_t                cidx;
   core_tag_t                last_core;
   unit_idx_t                sel;
   logic                     found;
   logic [`APU_NB_UNITS-1:0] taken;
   arb_state_e               state;

   //////////////////////////////////////////////////////////////
   // Rotating scan, one free unit per requesting core
   //////////////////////////////////////////////////////////////

   always_comb begin
      taken     = '0;
      cidx      = ptr_q;
      last_core = ptr_q;
      sel       = '0;
      found     = 1'b0;
      state     = arb_idle;

      for (int c = 0; c < `APU_NB_CORES; c++) begin
         ack_o[c] = 1'b0;
      end
      for (int u = 0; u < `APU_NB_UNITS; u++) begin
         issue_valid_o[u] = 1'b0;
         issue_op_o[u]    = op_mul_lo;
         issue_opa_o[u]   = '0;
         issue_opb_o[u]   = '0;
         issue_opc_o[u]   = '0;
         issue_tag_o[u]   = '0;
      end

      for (int k = 0; k < `APU_NB_CORES; k++) begin
         // Wraps by truncation, core count is a power of two
         cidx = ptr_q + core_tag_t'(k);
         if (req_i[cidx]) begin
            found = 1'b0;
            sel   = '0;
            // Downward walk leaves the lowest free unit in sel
            for (int u = `APU_NB_UNITS-1; u >= 0; u--) begin
               if (unit_ready_i[u] && !taken[u]) begin
                  found = 1'b1;
                  sel   = unit_idx_t'(u);
               end
            end
            if (found) begin
               taken[sel]         = 1'b1;
               ack_o[cidx]        = 1'b1;
               issue_valid_o[sel] = 1'b1;
               issue_op_o[sel]    = op_i[cidx];
               issue_opa_o[sel]   = opa_i[cidx];
               issue_opb_o[sel]   = opb_i[cidx];
               issue_opc_o[sel]   = opc_i[cidx];
               issue_tag_o[sel]   = cidx;
               last_core          = cidx;
               state              = arb_granting;
            end
         end
      end
   end

   // Next scan starts after the last core served
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         ptr_q <= '0;
      end else if (state == arb_granting) begin
         ptr_q <= last_core + core_tag_t'(1);
      end
   end

   // A core's request never lands in two units at once
   for (genvar a = 0; a < `APU_NB_UNITS; a++) begin : g_chk_a
      for (genvar b = a + 1; b < `APU_NB_UNITS; b++) begin : g_chk_b
         a_no_double_issue : assert property (
            @(posedge clk_i) disable iff (reset_i)
            !(issue_valid_o[a] && issue_valid_o[b] && (issue_tag_o[a] == issue_tag_o[b]))
         );
      end
   end

endmodule

// File: source/apu_mult_unit.sv
`timescale 1ns/1ps
`include "apu_macros.svh"

module apu_mult_unit (
   input  logic                        clk_i,
   input  logic                        reset_i,
   // Issue from the arbiter
   input  logic                        issue_valid_i,
   input  apu_types_pkg::apu_op_e      issue_op_i,
   input  apu_types_pkg::apu_operand_t issue_opa_i,
   input  apu_types_pkg::apu_operand_t issue_opb_i,
   input  apu_types_pkg::apu_operand_t issue_opc_i,
   input  apu_cluster_pkg::core_tag_t  issue_tag_i,
   output logic                        unit_ready_o,
   // Result towards the router
   output logic                        out_valid_o,
   output apu_types_pkg::apu_result_t  out_result_o,
   output apu_cluster_pkg::core_tag_t  out_tag_o,
   input  logic                        out_ack_i
);

   import apu_types_pkg::*;
   import apu_cluster_pkg::*;

   logic         signed_ops;
   apu_product_t ext_a;
   apu_product_t ext_b;
   apu_product_t product;
   apu_result_t  result_d;
   logic         advance;

   // Pipeline registers
   logic         valid_q  [`APU_MULT_STAGES-1:0];
   apu_result_t  result_q [`APU_MULT_STAGES-1:0];
   core_tag_t    tag_q    [`APU_MULT_STAGES-1:0];

   //////////////////////////////////////////////////////////////
   // Multiply and select
   //////////////////////////////////////////////////////////////

   // Only the signed high product needs sign extension
   assign signed_ops = (issue_op_i == op_mulh_ss);

   assign ext_a = {{`APU_WIDTH{signed_ops & issue_opa_i[`APU_WIDTH-1]}}, issue_opa_i};
   assign ext_b = {{`APU_WIDTH{signed_ops & issue_opb_i[`APU_WIDTH-1]}}, issue_opb_i};

   // Low 64 bits are exact for both signed and unsigned inputs
   assign product = ext_a * ext_b;

   always_comb begin
      case (issue_op_i)
         op_mulh_ss,
         op_mulh_uu: result_d = product[2*`APU_WIDTH-1:`APU_WIDTH];
         op_mac_lo:  result_d = product[`APU_WIDTH-1:0] + issue_opc_i;
         default:    result_d = product[`APU_WIDTH-1:0];
      endcase
   end

   //////////////////////////////////////////////////////////////
   // Pipeline with global stall
   //////////////////////////////////////////////////////////////

   // Whole pipe freezes while the last stage waits for its ack
   assign advance      = !(valid_q[`APU_MULT_STAGES-1] && !out_ack_i);
   assign unit_ready_o = advance;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         for (int s = 0; s < `APU_MULT_STAGES; s++) begin
            valid_q[s] <= 1'b0;
         end
      end else if (advance) begin
         valid_q[0] <= issue_valid_i;
         for (int s = 1; s < `APU_MULT_STAGES; s++) begin
            valid_q[s] <= valid_q[s-1];
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (advance) begin
         result_q[0] <= result_d;
         tag_q[0]    <= issue_tag_i;
         for (int s = 1; s < `APU_MULT_STAGES; s++) begin
            result_q[s] <= result_q[s-1];
            tag_q[s]    <= tag_q[s-1];
         end
      end
   end

   assign out_valid_o  = valid_q[`APU_MULT_STAGES-1];
   assign out_result_o = result_q[`APU_MULT_STAGES-1];
   assign out_tag_o    = tag_q[`APU_MULT_STAGES-1];

   // Held result and tag must not move until the router takes them
   a_hold_when_stalled : assert property (
      @(posedge clk_i) disable iff (reset_i)
      (out_valid_o && !out_ack_i) |=>
         (out_valid_o && $stable(out_result_o) && $stable(out_tag_o))
   );

endmodule

// File: source/apu_result_router.sv
`timescale 1ns/1ps
`include "apu_macros.svh"

module apu_result_router (
   input  logic                       clk_i,
   input  logic                       reset_i,
   // Unit results
   input  logic                       out_valid_i  [`APU_NB_UNITS-1:0],
   input  apu_types_pkg::apu_result_t out_result_i [`APU_NB_UNITS-1:0],
   input  apu_cluster_pkg::core_tag_t out_tag_i    [`APU_NB_UNITS-1:0],
   output logic                       out_ack_o    [`APU_NB_UNITS-1:0],
   // Core result ports
   output logic                       valid_o      [`APU_NB_CORES-1:0],
   output apu_types_pkg::apu_result_t result_o     [`APU_NB_CORES-1:0],
   input  logic                       ready_i      [`APU_NB_CORES-1:0]
);

   import apu_types_pkg::*;
   import apu_cluster_pkg::*;

   logic                     can_load   [`APU_NB_CORES-1:0];
   logic                     load_en    [`APU_NB_CORES-1:0];
   unit_idx_t                load_sel   [`APU_NB_CORES-1:0];
   logic [`APU_NB_CORES-1:0] claim      [`APU_NB_UNITS-1:0];

   // Per-core output register
   logic                     res_valid_q [`APU_NB_CORES-1:0];
   apu_result_t              res_q       [`APU_NB_CORES-1:0];

   //////////////////////////////////////////////////////////////
   // Source selection per core
   //////////////////////////////////////////////////////////////

   always_comb begin
      for (int c = 0; c < `APU_NB_CORES; c++) begin
         // Register is free or being drained this cycle
         can_load[c] = !res_valid_q[c] || ready_i[c];
         load_en[c]  = 1'b0;
         load_sel[c] = '0;
         // Lowest matching unit wins
         for (int u = `APU_NB_UNITS-1; u >= 0; u--) begin
            if (out_valid_i[u] && (out_tag_i[u] == core_tag_t'(c))) begin
               load_en[c]  = can_load[c];
               load_sel[c] = unit_idx_t'(u);
            end
         end
      end
   end

   // Which cores take each unit's result
   always_comb begin
      for (int u = 0; u < `APU_NB_UNITS; u++) begin
         for (int c = 0; c < `APU_NB_CORES; c++) begin
            claim[u][c] = load_en[c] && (load_sel[c] == unit_idx_t'(u));
         end
         out_ack_o[u] = |claim[u];
      end
   end

   //////////////////////////////////////////////////////////////
   // Output registers
   //////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         for (int c = 0; c < `APU_NB_CORES; c++) begin
            res_valid_q[c] <= 1'b0;
         end
      end else begin
         for (int c = 0; c < `APU_NB_CORES; c++) begin
            if (load_en[c]) begin
               res_valid_q[c] <= 1'b1;
            end else if (ready_i[c]) begin
               res_valid_q[c] <= 1'b0;
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      for (int c = 0; c < `APU_NB_CORES; c++) begin
         if (load_en[c]) begin
            res_q[c] <= out_result_i[load_sel[c]];
         end
      end
   end

   always_comb begin
      for (int c = 0; c < `APU_NB_CORES; c++) begin
         valid_o[c]  = res_valid_q[c];
         result_o[c] = res_q[c];
      end
   end

   // A unit result is delivered to one core only
   for (genvar u = 0; u < `APU_NB_UNITS; u++) begin : g_chk_unit
      a_single_taker : assert property (
         @(posedge clk_i) disable iff (reset_i)
         $onehot0(claim[u])
      );
   end

endmodule

// File: source/apu_cluster.sv
`timescale 1ns/1ps
`include "apu_macros.svh"

module apu_cluster (
   input  logic                        clk_i,
   input  logic                        reset_i,
   // Request side per core
   input  logic                        req_i    [`APU_NB_CORES-1:0],
   input  apu_types_pkg::apu_op_e      op_i     [`APU_NB_CORES-1:0],
   input  apu_types_pkg::apu_operand_t opa_i    [`APU_NB_CORES-1:0],
   input  apu_types_pkg::apu_operand_t opb_i    [`APU_NB_CORES-1:0],
   input  apu_types_pkg::apu_operand_t opc_i    [`APU_NB_CORES-1:0],
   output logic                        ack_o    [`APU_NB_CORES-1:0],
   // Result side per core
   output logic                        valid_o  [`APU_NB_CORES-1:0],
   output apu_types_pkg::apu_result_t  result_o [`APU_NB_CORES-1:0],
   input  logic                        ready_i  [`APU_NB_CORES-1:0]
);

   import apu_types_pkg::*;
   import apu_cluster_pkg::*;

   // Arbiter to units
   logic         unit_ready  [`APU_NB_UNITS-1:0];
   logic         issue_valid [`APU_NB_UNITS-1:0];
   apu_op_e      issue_op    [`APU_NB_UNITS-1:0];
   apu_operand_t issue_opa   [`APU_NB_UNITS-1:0];
   apu_operand_t issue_opb   [`APU_NB_UNITS-1:0];
   apu_operand_t issue_opc   [`APU_NB_UNITS-1:0];
   core_tag_t    issue_tag   [`APU_NB_UNITS-1:0];

   // Units to router
   logic         out_valid   [`APU_NB_UNITS-1:0];
   apu_result_t  out_result  [`APU_NB_UNITS-1:0];
   core_tag_t    out_tag     [`APU_NB_UNITS-1:0];
   logic         out_ack     [`APU_NB_UNITS-1:0];

   apu_arbiter i_apu_arbiter (
      .clk_i         ( clk_i       ),
      .reset_i       ( reset_i     ),
      .req_i         ( req_i       ),
      .op_i          ( op_i        ),
      .opa_i         ( opa_i       ),
      .opb_i         ( opb_i       ),
      .opc_i         ( opc_i       ),
      .ack_o         ( ack_o       ),
      .unit_ready_i  ( unit_ready  ),
      .issue_valid_o ( issue_valid ),
      .issue_op_o    ( issue_op    ),
      .issue_opa_o   ( issue_opa   ),
      .issue_opb_o   ( issue_opb   ),
      .issue_opc_o   ( issue_opc   ),
      .issue_tag_o   ( issue_tag   )
   );

   // Shared multiply pool
   for (genvar u = 0; u < `APU_NB_UNITS; u++) begin : g_unit
      apu_mult_unit i_apu_mult_unit (
         .clk_i         ( clk_i          ),
         .reset_i       ( reset_i        ),
         .issue_valid_i ( issue_valid[u] ),
         .issue_op_i    ( issue_op[u]    ),
         .issue_opa_i   ( issue_opa[u]   ),
         .issue_opb_i   ( issue_opb[u]   ),
         .issue_opc_i   ( issue_opc[u]   ),
         .issue_tag_i   ( issue_tag[u]   ),
         .unit_ready_o  ( unit_ready[u]  ),
         .out_valid_o   ( out_valid[u]   ),
         .out_result_o  ( out_result[u]  ),
         .out_tag_o     ( out_tag[u]     ),
         .out_ack_i     ( out_ack[u]     )
      );
   end

   apu_result_router i_apu_result_router (
      .clk_i        ( clk_i      ),
      .reset_i      ( reset_i    ),
      .out_valid_i  ( out_valid  ),
      .out_result_i ( out_result ),
      .out_tag_i    ( out_tag    ),
      .out_ack_o    ( out_ack    ),
      .valid_o      ( valid_o    ),
      .result_o     ( result_o   ),
      .ready_i      ( ready_i    )
   );

endmodule

// File: bench/apu_cluster_tb.sv
`timescale 1ns/1ps
`include "apu_macros.svh"

module apu_cluster_tb;

   import apu_types_pkg::*;
   import apu_cluster_pkg::*;

   localparam int NC       = `APU_NB_CORES;
   localparam int W        = `APU_WIDTH;
   localparam int MAX_ROWS = 128;
   localparam int ACK_WAIT = 20;

   logic         clk_i;
   logic         reset_i;
   logic         req    [NC-1:0];
   apu_op_e      op     [NC-1:0];
   apu_operand_t opa    [NC-1:0];
   apu_operand_t opb    [NC-1:0];
   apu_operand_t opc    [NC-1:0];
   logic         ack    [NC-1:0];
   logic         valid  [NC-1:0];
   apu_result_t  result [NC-1:0];
   logic         ready  [NC-1:0];

   // Stimulus table with one row per request
   core_tag_t    row_core  [MAX_ROWS];
   apu_op_e      row_op    [MAX_ROWS];
   apu_operand_t row_a     [MAX_ROWS];
   apu_operand_t row_b     [MAX_ROWS];
   apu_operand_t row_c     [MAX_ROWS];
   logic [7:0]   row_ready [MAX_ROWS];
   apu_result_t  row_exp   [MAX_ROWS];
   int           row_test  [MAX_ROWS];

   int     n_rows;
   int     errors;
   int     checks;
   int     drivers_done;
   integer seed;

   // Request in flight per core
   logic   pend_vld [NC-1:0];
   int     pend_row [NC-1:0];

   apu_cluster i_apu_cluster (
      .clk_i    ( clk_i   ),
      .reset_i  ( reset_i ),
      .req_i    ( req     ),
      .op_i     ( op      ),
      .opa_i    ( opa     ),
      .opb_i    ( opb     ),
      .opc_i    ( opc     ),
      .ack_o    ( ack     ),
      .valid_o  ( valid   ),
      .result_o ( result  ),
      .ready_i  ( ready   )
   );

   initial begin
      clk_i = 1'b0;
      forever #4 clk_i = ~clk_i;
   end

   //////////////////////////////////////////////////////////////
   // Compare tasks and reference model
   //////////////////////////////////////////////////////////////

   task automatic check_result(input apu_result_t got, input apu_result_t exp,
                               input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail at %0t ns: %s, got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_tag(input core_tag_t got, input core_tag_t exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail at %0t ns: %s, got core %0d expected core %0d", $time, what, got, exp);
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail at %0t ns: %s, got %b expected %b", $time, what, got, exp);
      end
   endtask

   // Low word, signed or unsigned high word, or low word plus c
   function automatic apu_result_t model_result(input apu_op_e o, input apu_operand_t a,
                                                input apu_operand_t b, input apu_operand_t c);
      logic signed [2*W-1:0] sa;
      logic signed [2*W-1:0] sb;
      logic [2*W-1:0]        ua;
      logic [2*W-1:0]        ub;
      logic signed [2*W-1:0] sprod;
      logic [2*W-1:0]        uprod;
      sa    = $signed(a);
      sb    = $signed(b);
      ua    = {{W{1'b0}}, a};
      ub    = {{W{1'b0}}, b};
      sprod = sa * sb;
      uprod = ua * ub;
      case (o)
         op_mulh_ss: return sprod[2*W-1:W];
         op_mulh_uu: return uprod[2*W-1:W];
         op_mac_lo:  return uprod[W-1:0] + c;
         default:    return uprod[W-1:0];
      endcase
   endfunction

   // Find which pending request a delivered value belongs to
   function automatic core_tag_t result_owner(input int c, input apu_result_t value);
      core_tag_t owner;
      owner = core_tag_t'(c);
      if (row_exp[pend_row[c]] !== value) begin
         for (int d = 0; d < NC; d++) begin
            if (d != c && pend_vld[d] && row_exp[pend_row[d]] === value) begin
               owner = core_tag_t'(d);
            end
         end
      end
      return owner;
   endfunction

   task automatic add_row(input int core, input apu_op_e o, input apu_operand_t a,
                          input apu_operand_t b, input apu_operand_t c,
                          input logic [7:0] pat, input int test);
      row_core[n_rows]  = core_tag_t'(core);
      row_op[n_rows]    = o;
      row_a[n_rows]     = a;
      row_b[n_rows]     = b;
      row_c[n_rows]     = c;
      row_ready[n_rows] = pat;
      row_exp[n_rows]   = model_result(o, a, b, c);
      row_test[n_rows]  = test;
      n_rows++;
   endtask

   task automatic build_table();
      apu_operand_t edge_a [4];
      apu_operand_t edge_b [4];
      logic [1:0]   ob;
      logic [31:0]  r;
      edge_a = '{32'h8000_0000, 32'hFFFF_FFFF, 32'h7FFF_FFFF, 32'hFFFF_FFFF};
      edge_b = '{32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000, 32'h0000_0002};
      for (int o = 0; o < 4; o++) begin
         for (int p = 0; p < 4; p++) begin
            ob = o[1:0];
            add_row(0, apu_op_e'(ob), edge_a[p], edge_b[p], 32'hFFFF_FFF0, 8'hFF, 2);
         end
      end
      // Distinct operands per core so a misrouted result shows
      for (int c = 0; c < NC; c++) begin
         add_row(c, op_mac_lo, apu_operand_t'(c + 3), 32'h0101_0101, apu_operand_t'(c),
                 8'hFF, 3);
         add_row(c, op_mulh_uu, 32'hF000_0000 | apu_operand_t'(c), 32'h1234_5678, '0,
                 8'hFF, 3);
      end
      // Core 1 stalls its result register
      add_row(1, op_mul_lo, 32'h0000_BEEF, 32'h0000_0011, '0, 8'h00, 4);
      add_row(1, op_mulh_ss, 32'hDEAD_0000, 32'h0000_7777, '0, 8'h08, 4);
      for (int k = 0; k < 3; k++) begin
         add_row(0, op_mac_lo, apu_operand_t'(k + 10), 32'h0000_0101, 32'h5, 8'hFF, 4);
         add_row(2, op_mulh_uu, 32'hFFFF_0000, apu_operand_t'(k + 20), '0, 8'hFF, 4);
         add_row(3, op_mul_lo, 32'hABCD_0001, apu_operand_t'(k + 30), '0, 8'hFF, 4);
      end
      for (int k = 0; k < 40; k++) begin
         r  = $random(seed);
         ob = r[1:0];
         add_row(k % NC, apu_op_e'(ob), $random(seed), $random(seed), $random(seed),
                 r[15:8], 5);
      end
   endtask

   //////////////////////////////////////////////////////////////
   // Per-core request driver and result collector
   //////////////////////////////////////////////////////////////

   task automatic apply_core(input int c, input int test);
      int waited;
      for (int r = 0; r < n_rows; r++) begin
         if (row_test[r] == test && row_core[r] == core_tag_t'(c)) begin
            @(negedge clk_i);
            req[c] = 1'b1;
            op[c]  = row_op[r];
            opa[c] = row_a[r];
            opb[c] = row_b[r];
            opc[c] = row_c[r];
            waited = 0;
            #1;
            while (!ack[c]) begin
               @(negedge clk_i);
               #1;
               waited++;
               if (waited == ACK_WAIT) begin
                  errors++;
                  $display("Core %0d got no ack within %0d cycles", c, ACK_WAIT);
               end
            end
            pend_row[c] = r;
            pend_vld[c] = 1'b1;
            @(negedge clk_i);
            req[c] = 1'b0;
            wait (!pend_vld[c]);
         end
      end
      drivers_done++;
   endtask

   task automatic collect_results(input int c);
      int          row;
      int          held_cycles;
      logic        held;
      logic        take;
      logic [2:0]  bit_idx;
      held        = 1'b0;
      held_cycles = 0;
      forever begin
         @(negedge clk_i);
         if (!valid[c]) begin
            ready[c] = 1'b0;
            if (held) begin
               errors++;
               $display("Core %0d dropped valid_o while its result was held", c);
               held = 1'b0;
            end
         end else if (!pend_vld[c]) begin
            ready[c] = 1'b1;
            errors++;
            $display("Core %0d got a result with no request outstanding", c);
         end else begin
            row = pend_row[c];
            if (held) begin
               check_result(result[c], row_exp[row],
                            $sformatf("core %0d held result of row %0d", c, row));
            end
            bit_idx  = held_cycles[2:0];
            take     = (held_cycles >= 8) || row_ready[row][bit_idx];
            ready[c] = take;
            if (take) begin
               check_result(result[c], row_exp[row], $sformatf("core %0d row %0d", c, row));
               check_tag(result_owner(c, result[c]), core_tag_t'(c),
                         $sformatf("owner of result at core %0d", c));
               held        = 1'b0;
               held_cycles = 0;
               pend_vld[c] = 1'b0;
            end else begin
               held = 1'b1;
               held_cycles++;
            end
         end
      end
   endtask

   task automatic run_test(input int test, input string name);
      int e0;
      int c0;
      e0           = errors;
      c0           = checks;
      drivers_done = 0;
      for (int c = 0; c < NC; c++) begin
         automatic int cc = c;
         fork
            apply_core(cc, test);
         join_none
      end
      wait (drivers_done == NC);
      $display("Test %0d (%s): %0d checks, %0d errors", test, name, checks - c0, errors - e0);
   endtask

   initial begin
      @(negedge reset_i);
      for (int c = 0; c < NC; c++) begin
         automatic int cc = c;
         fork
            collect_results(cc);
         join_none
      end
   end

   // Watchdog sized from the table length
   initial begin
      #1;
      repeat (n_rows * 50 + 20) @(posedge clk_i);
      $display("Timeout: run did not finish within %0d cycles", n_rows * 50 + 20);
      $display("CHECKS FAILED");
      $finish;
   end

   initial begin
      int c0;
      reset_i = 1'b1;
      for (int c = 0; c < NC; c++) begin
         req[c]      = 1'b0;
         op[c]       = op_mul_lo;
         opa[c]      = '0;
         opb[c]      = '0;
         opc[c]      = '0;
         ready[c]    = 1'b0;
         pend_vld[c] = 1'b0;
         pend_row[c] = 0;
      end
      errors = 0;
      checks = 0;
      n_rows = 0;
      seed   = 32'h8675;
      build_table();
      repeat (10) @(posedge clk_i);
      @(negedge clk_i);
      reset_i = 1'b0;

      // Idle outputs after reset
      c0 = checks;
      repeat (4) begin
         @(negedge clk_i);
         #1;
         for (int c = 0; c < NC; c++) begin
            check_flag(ack[c], 1'b0, $sformatf("core %0d ack_o after reset", c));
            check_flag(valid[c], 1'b0, $sformatf("core %0d valid_o after reset", c));
         end
      end
      $display("Test 1 (reset state): %0d checks, %0d errors", checks - c0, errors);

      run_test(2, "operations with edge operands");
      run_test(3, "all cores at once");
      run_test(4, "result back-pressure");
      run_test(5, "random stream");

      $display("Totals: %0d checks, %0d errors, %0d rows", checks, errors, n_rows);
      if (errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

// File: compile.f
+incdir+include
source/apu_types_pkg.sv
source/apu_cluster_pkg.sv
source/apu_arbiter.sv
source/apu_mult_unit.sv
source/apu_result_router.sv
source/apu_cluster.sv
bench/apu_cluster_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the multiply cluster testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=apu_cluster_sim

verilator --binary --timing --assert -Wno-fatal \
   -f compile.f --top-module apu_cluster_tb \
   --Mdir "$OBJ" -o "$BIN"
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
   echo "Simulation reported errors, see $LOG"
   exit 1
fi

exit 0
